/* Bender.yml */
package:
  name: hl_core

sources:
  - source/hl_proto_pkg.sv
  - source/hl_radio_pkg.sv
  - source/hl_ds_parser.sv
  - source/hl_control.sv
  - source/hl_us_response.sv
  - source/hl_core.sv
  - target: test
    files:
      - bench/hl_core_tb.sv

/* bench/hl_core_tb.sv */
// HL control core testbench
// drives downstream frames, tracks a cycle-accurate reference model of
// the frame and control rules and checks the DUT against it

`timescale 1ns/100ps

module hl_core_tb
  import hl_proto_pkg::*, hl_radio_pkg::*;
;

  localparam int unsigned WD_LIMIT = 200;
  // stimulus runs for roughly 1,550 cycles
  localparam int unsigned TIMEOUT_CYCLES = 20_000;

  logic       clk_ctrl;
  logic       rst_n_i;
  hl_udp_rx_t udp_rx_i;
  logic       tx_inhibit_i;
  hl_udp_tx_t udp_tx_o;
  logic       led_run_o;
  logic       led_tx_o;
  logic       pa_inttr_o;
  logic       rffe_rfsw_sel_o;

  int unsigned  val_errs;
  int unsigned  other_errs;
  int unsigned  cycle_cnt;
  int unsigned  resp_cnt;
  int unsigned  last_cnt;
  int unsigned  wd_trips;
  hl_byte_t     frame_buf [0:7];

  // reference model state
  int unsigned  rx_idx;
  logic         rx_ok;
  hl_byte_t     rx_type;
  hl_cmd_t      rx_cmd;
  logic         run_pend;
  logic         run_val;
  logic         cmd_pend;
  hl_cmd_t      cmd_val;
  logic         resp_pend;
  logic         m_run;
  logic         m_ptt;
  hl_cmd_addr_t m_addr;
  hl_cmd_data_t m_rffe;
  hl_cmd_data_t m_pa;
  int unsigned  m_wd;
  hl_resp_t     m_resp;
  logic         m_tx_busy;
  int unsigned  m_tx_idx;
  logic         exp_tx_on;
  hl_cmd_data_t exp_rb;

  hl_core #(
    .WATCHDOG_CYCLES (WD_LIMIT)
  ) i_dut (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .udp_rx_i        (udp_rx_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .udp_tx_o        (udp_tx_o),
    .led_run_o       (led_run_o),
    .led_tx_o        (led_tx_o),
    .pa_inttr_o      (pa_inttr_o),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o)
  );

  always #10 clk_ctrl = ~clk_ctrl;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  assign exp_tx_on = m_ptt & ~tx_inhibit_i;
  assign exp_rb = (m_addr == HL_ADDR_RFFE) ? m_rffe :
                  (m_addr == HL_ADDR_PA) ? m_pa : '0;

  // response frame byte by position
  function automatic hl_byte_t tx_byte_at(input hl_resp_t r, input int unsigned idx);
    hl_byte_t frame [0:7];
    frame[0] = 8'hEF;
    frame[1] = 8'hFE;
    frame[2] = 8'h02;
    frame[3] = {r.run, r.addr, r.tx_on};
    frame[4] = r.data[31:24];
    frame[5] = r.data[23:16];
    frame[6] = r.data[15:8];
    frame[7] = r.data[7:0];
    return frame[idx];
  endfunction

  always @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      rx_idx    <= 0;
      rx_ok     <= 1'b1;
      rx_type   <= '0;
      rx_cmd    <= '0;
      run_pend  <= 1'b0;
      run_val   <= 1'b0;
      cmd_pend  <= 1'b0;
      cmd_val   <= '0;
      resp_pend <= 1'b0;
      m_run     <= 1'b0;
      m_ptt     <= 1'b0;
      m_addr    <= '0;
      m_rffe    <= '0;
      m_pa      <= '0;
      m_wd      <= 0;
      m_resp    <= '0;
      m_tx_busy <= 1'b0;
      m_tx_idx  <= 0;
    end else begin
      run_pend  <= 1'b0;
      cmd_pend  <= 1'b0;
      resp_pend <= 1'b0;
      // frame decode, one stage ahead of the control model
      if (!udp_rx_i.active) begin
        rx_idx <= 0;
        rx_ok  <= 1'b1;
      end else if (udp_rx_i.valid) begin
        rx_idx <= rx_idx + 1;
        case (rx_idx)
          0: if (udp_rx_i.port != 16'd1024 || udp_rx_i.data != 8'hEF) rx_ok <= 1'b0;
          1: if (udp_rx_i.port != 16'd1024 || udp_rx_i.data != 8'hFE) rx_ok <= 1'b0;
          2: rx_type <= udp_rx_i.data;
          3: begin
            run_pend  <= rx_ok && rx_type == 8'h04;
            run_val   <= udp_rx_i.data[0];
            rx_cmd    <= {udp_rx_i.data[6:1], 32'h0, udp_rx_i.data[0], udp_rx_i.data[7]};
          end
          4, 5, 6: rx_cmd.data <= {rx_cmd.data[23:0], udp_rx_i.data};
          7: begin
            cmd_pend <= rx_ok && rx_type == 8'h01;
            cmd_val  <= {rx_cmd.addr, rx_cmd.data[23:0], udp_rx_i.data,
                         rx_cmd.ptt, rx_cmd.resp_rqst};
          end
          default: ;
        endcase
      end
      // control rules
      if (m_wd == WD_LIMIT) begin
        m_run    <= 1'b0;
        m_ptt    <= 1'b0;
        wd_trips <= wd_trips + 1;
      end
      if (run_pend) m_run <= run_val;
      if (cmd_pend) begin
        m_ptt     <= cmd_val.ptt;
        m_addr    <= cmd_val.addr;
        resp_pend <= cmd_val.resp_rqst;
        if (cmd_val.addr == 6'h00) m_rffe <= cmd_val.data;
        if (cmd_val.addr == 6'h09) m_pa <= cmd_val.data;
      end
      if (run_pend || cmd_pend || !m_run || m_wd == WD_LIMIT) m_wd <= 0;
      else m_wd <= m_wd + 1;
      // response frame
      if (resp_pend) begin
        m_resp    <= '{run: m_run, addr: m_addr, tx_on: exp_tx_on, data: exp_rb};
        m_tx_busy <= 1'b1;
        m_tx_idx  <= 0;
        resp_cnt  <= resp_cnt + 1;
      end else if (m_tx_busy) begin
        m_tx_idx <= m_tx_idx + 1;
        if (m_tx_idx == 7) m_tx_busy <= 1'b0;
      end
      if (udp_tx_o.valid && udp_tx_o.last) last_cnt <= last_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i) led_run_o == m_run)
    else begin
      val_errs++;
      $display("ERR %0t led_run_o exp %0b got %0b", $time, $sampled(m_run), $sampled(led_run_o));
    end
  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i) led_tx_o == exp_tx_on)
    else begin
      val_errs++;
      $display("ERR %0t led_tx_o exp %0b got %0b", $time, $sampled(exp_tx_on), $sampled(led_tx_o));
    end
  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    pa_inttr_o == (exp_tx_on & m_pa[0]))
    else begin
      val_errs++;
      $display("ERR %0t pa_inttr_o exp %0b got %0b", $time,
               $sampled(exp_tx_on & m_pa[0]), $sampled(pa_inttr_o));
    end
  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i) rffe_rfsw_sel_o == m_rffe[0])
    else begin
      val_errs++;
      $display("ERR %0t rffe_rfsw_sel_o exp %0b got %0b", $time,
               $sampled(m_rffe[0]), $sampled(rffe_rfsw_sel_o));
    end
  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i) udp_tx_o.valid == m_tx_busy)
    else begin
      val_errs++;
      $display("ERR %0t udp_tx_o.valid exp %0b got %0b", $time,
               $sampled(m_tx_busy), $sampled(udp_tx_o.valid));
    end
  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    udp_tx_o.last == (m_tx_busy && m_tx_idx == 7))
    else begin
      val_errs++;
      $display("ERR %0t udp_tx_o.last exp %0b got %0b", $time,
               $sampled(m_tx_busy && m_tx_idx == 7), $sampled(udp_tx_o.last));
    end
  assert property (@(posedge clk_ctrl) disable iff (!rst_n_i)
    !m_tx_busy || udp_tx_o.data == tx_byte_at(m_resp, m_tx_idx))
    else begin
      val_errs++;
      $display("ERR %0t udp_tx_o.data exp %02h got %02h", $time,
               tx_byte_at($sampled(m_resp), $sampled(m_tx_idx)), $sampled(udp_tx_o.data));
    end

  // hang guard
  always @(posedge clk_ctrl) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: stimulus did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_ctrl);
  endtask

  // one byte strobe, then one idle cycle
  task automatic send_frame(input hl_port_t port, input int len);
    for (int i = 0; i < len; i++) begin
      @(negedge clk_ctrl);
      udp_rx_i.active = 1'b1;
      udp_rx_i.valid  = 1'b1;
      udp_rx_i.port   = port;
      udp_rx_i.data   = frame_buf[i];
      @(negedge clk_ctrl);
      udp_rx_i.valid = 1'b0;
    end
    @(negedge clk_ctrl);
    udp_rx_i.active = 1'b0;
    @(negedge clk_ctrl);
  endtask

  task automatic send_run(input hl_port_t port, input hl_byte_t sync0,
                          input hl_byte_t ftype, input logic run);
    frame_buf[0] = sync0;
    frame_buf[1] = 8'hFE;
    frame_buf[2] = ftype;
    frame_buf[3] = {7'h0, run};
    send_frame(port, 4);
  endtask

  task automatic send_cmd(input hl_cmd_addr_t addr, input hl_cmd_data_t data,
                          input logic ptt, input logic rqst, input int len = 8);
    frame_buf[0] = 8'hEF;
    frame_buf[1] = 8'hFE;
    frame_buf[2] = 8'h01;
    frame_buf[3] = {rqst, addr, ptt};
    frame_buf[4] = data[31:24];
    frame_buf[5] = data[23:16];
    frame_buf[6] = data[15:8];
    frame_buf[7] = data[7:0];
    send_frame(16'd1024, len);
  endtask

  initial begin
    hl_cmd_addr_t addr;
    clk_ctrl     = 1'b0;
    rst_n_i      = 1'b0;
    udp_rx_i     = '0;
    tx_inhibit_i = 1'b0;
    val_errs     = 0;
    other_errs   = 0;
    cycle_cnt    = 0;
    resp_cnt     = 0;
    last_cnt     = 0;
    wd_trips     = 0;
    void'($urandom(14));
    wait_cycles(5);
    rst_n_i = 1'b1;
    wait_cycles(4);

    // start/stop frames, wrong port, bad header, unknown type
    send_run(16'd1024, 8'hEF, 8'h04, 1'b1);
    send_run(16'd1024, 8'hEF, 8'h04, 1'b0);
    send_run(16'd1025, 8'hEF, 8'h04, 1'b1);
    send_run(16'd1024, 8'hEE, 8'h04, 1'b1);
    send_run(16'd1024, 8'hEF, 8'h07, 1'b1);

    // register writes, ptt and inhibit
    send_cmd(6'h00, 32'h0000_0001, 1'b0, 1'b0);
    send_cmd(6'h09, 32'h0000_0001, 1'b1, 1'b0);
    wait_cycles(4);
    tx_inhibit_i = 1'b1;
    wait_cycles(4);
    tx_inhibit_i = 1'b0;
    wait_cycles(4);
    send_cmd(6'h09, 32'h0000_0000, 1'b0, 1'b0);
    send_cmd(6'h09, 32'hFFFF_FFFF, 1'b1, 1'b1, 6);

    // responses, mapped and unmapped address
    send_cmd(6'h00, 32'h1234_5678, 1'b0, 1'b1);
    send_cmd(6'h3F, 32'hDEAD_BEEF, 1'b1, 1'b1);

    // watchdog, kept alive and then left to expire
    send_run(16'd1024, 8'hEF, 8'h04, 1'b1);
    send_cmd(6'h09, 32'h0000_0001, 1'b1, 1'b0);
    wait_cycles(150);
    send_cmd(6'h09, 32'h0000_0001, 1'b1, 1'b0);
    wait_cycles(150);
    wait_cycles(100);

    // random commands
    send_run(16'd1024, 8'hEF, 8'h04, 1'b1);
    for (int n = 0; n < 50; n++) begin
      case ($urandom % 3)
        0: addr = 6'h00;
        1: addr = 6'h09;
        default: addr = 6'($urandom);
      endcase
      tx_inhibit_i = 1'($urandom);
      send_cmd(addr, $urandom, 1'($urandom), 1'($urandom));
    end
    wait_cycles(12);

    if (last_cnt != resp_cnt || resp_cnt == 0) begin
      other_errs++;
      $display("response count wrong: %0d frames expected, %0d seen", resp_cnt, last_cnt);
    end
    if (wd_trips == 0) begin
      other_errs++;
      $display("watchdog never expired during the run");
    end
    $display("error counts: %0d value, %0d other", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* hl_core.f */
source/hl_proto_pkg.sv
source/hl_radio_pkg.sv
source/hl_ds_parser.sv
source/hl_control.sv
source/hl_us_response.sv
source/hl_core.sv
bench/hl_core_tb.sv

/* source/hl_control.sv */
// HL control block
// command registers, transmit state, board outputs and the host
// watchdog; raises a response request with the register readback

`timescale 1ns/100ps

module hl_control
  import hl_radio_pkg::*;
#(
  parameter int unsigned WATCHDOG_CYCLES = 2_000_000
) (
  input  logic     clk_ctrl,
  input  logic     rst_n_i,
  input  logic     run_stb_i,
  input  logic     run_i,
  input  logic     cmd_stb_i,
  input  hl_cmd_t  cmd_i,
  input  logic     tx_inhibit_i,
  output logic     resp_stb_o,
  output hl_resp_t resp_o,
  output logic     led_run_o,
  output logic     led_tx_o,
  output logic     pa_inttr_o,
  output logic     rffe_rfsw_sel_o
);

  localparam int unsigned WD_W = $clog2(WATCHDOG_CYCLES + 1);

  logic            run_q;
  logic            ptt_q;
  hl_cmd_addr_t    addr_q;
  hl_cmd_data_t    rffe_q;
  hl_cmd_data_t    pa_q;
  hl_cmd_data_t    readback;
  logic [WD_W-1:0] wd_cnt_q;
  logic            wd_expired;
  logic            host_stb;
  logic            tx_on;

  assign host_stb   = run_stb_i | cmd_stb_i;
  assign wd_expired = (wd_cnt_q == WD_W'(WATCHDOG_CYCLES));

  ////////////////////////////////////////////////////////////
  // registers and watchdog
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      run_q      <= 1'b0;
      ptt_q      <= 1'b0;
      addr_q     <= '0;
      rffe_q     <= '0;
      pa_q       <= '0;
      wd_cnt_q   <= '0;
      resp_stb_o <= 1'b0;
    end else begin
      resp_stb_o <= cmd_stb_i & cmd_i.resp_rqst;
      // host went quiet
      if (wd_expired) begin
        run_q <= 1'b0;
        ptt_q <= 1'b0;
      end
      if (run_stb_i) begin
        run_q <= run_i;
      end
      if (cmd_stb_i) begin
        ptt_q  <= cmd_i.ptt;
        addr_q <= cmd_i.addr;
        if (cmd_i.addr == HL_ADDR_RFFE) rffe_q <= cmd_i.data;
        if (cmd_i.addr == HL_ADDR_PA) pa_q <= cmd_i.data;
      end
      // counts only while running
      if (host_stb || !run_q || wd_expired) begin
        wd_cnt_q <= '0;
      end else begin
        wd_cnt_q <= wd_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs and readback
  ////////////////////////////////////////////////////////////

  assign tx_on = ptt_q & ~tx_inhibit_i;

  assign led_run_o       = run_q;
  assign led_tx_o        = tx_on;
  assign pa_inttr_o      = tx_on & pa_q[0];
  assign rffe_rfsw_sel_o = rffe_q[0];

  // unmapped addresses read as zero
  always_comb begin
    case (addr_q)
      HL_ADDR_RFFE: readback = rffe_q;
      HL_ADDR_PA:   readback = pa_q;
      default:      readback = '0;
    endcase
  end

  assign resp_o.run   = run_q;
  assign resp_o.addr  = addr_q;
  assign resp_o.tx_on = tx_on;
  assign resp_o.data  = readback;

endmodule

/* source/hl_core.sv */
// HL control core top level
// downstream parser, control block and upstream response sender,
// all on the control clock

`timescale 1ns/100ps

module hl_core
  import hl_proto_pkg::*, hl_radio_pkg::*;
#(
  parameter int unsigned WATCHDOG_CYCLES = 2_000_000
) (
  input  logic       clk_ctrl,
  input  logic       rst_n_i,
  input  hl_udp_rx_t udp_rx_i,
  input  logic       tx_inhibit_i,
  output hl_udp_tx_t udp_tx_o,
  output logic       led_run_o,
  output logic       led_tx_o,
  output logic       pa_inttr_o,
  output logic       rffe_rfsw_sel_o
);

  logic     run_stb;
  logic     run;
  logic     cmd_stb;
  hl_cmd_t  cmd;
  logic     resp_stb;
  hl_resp_t resp;

  ////////////////////////////////////////////////////////////
  // downstream
  ////////////////////////////////////////////////////////////

  hl_ds_parser i_parser (
    .clk_ctrl  (clk_ctrl),
    .rst_n_i   (rst_n_i),
    .udp_rx_i  (udp_rx_i),
    .run_stb_o (run_stb),
    .run_o     (run),
    .cmd_stb_o (cmd_stb),
    .cmd_o     (cmd)
  );

  // registers, tx state and board io
  hl_control #(
    .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
  ) i_control (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .run_stb_i       (run_stb),
    .run_i           (run),
    .cmd_stb_i       (cmd_stb),
    .cmd_i           (cmd),
    .tx_inhibit_i    (tx_inhibit_i),
    .resp_stb_o      (resp_stb),
    .resp_o          (resp),
    .led_run_o       (led_run_o),
    .led_tx_o        (led_tx_o),
    .pa_inttr_o      (pa_inttr_o),
    .rffe_rfsw_sel_o (rffe_rfsw_sel_o)
  );

  ////////////////////////////////////////////////////////////
  // upstream
  ////////////////////////////////////////////////////////////

  hl_us_response i_response (
    .clk_ctrl   (clk_ctrl),
    .rst_n_i    (rst_n_i),
    .resp_stb_i (resp_stb),
    .resp_i     (resp),
    .udp_tx_o   (udp_tx_o)
  );

endmodule

/* source/hl_ds_parser.sv */
// HL downstream parser
// checks port and sync header of incoming UDP frames and decodes
// start/stop and command frames into single-cycle strobes

`timescale 1ns/100ps

module hl_ds_parser
  import hl_proto_pkg::*, hl_radio_pkg::*;
(
  input  logic       clk_ctrl,
  input  logic       rst_n_i,
  input  hl_udp_rx_t udp_rx_i,
  output logic       run_stb_o,
  output logic       run_o,
  output logic       cmd_stb_o,
  output hl_cmd_t    cmd_o
);

  typedef enum logic [2:0] {
    ST_HDR,
    ST_TYPE,
    ST_RUN,
    ST_CMD,
    ST_DISCARD
  } state_t;

  state_t     state_q;
  logic [2:0] byte_cnt_q;
  hl_cmd_t    cmd_q;
  logic       byte_stb;
  hl_byte_t   rx_byte;
  logic       port_ok;

  assign byte_stb = udp_rx_i.active & udp_rx_i.valid;
  assign rx_byte  = udp_rx_i.data;
  assign port_ok  = (udp_rx_i.port == HL_DS_PORT);

  ////////////////////////////////////////////////////////////
  // frame state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      state_q    <= ST_HDR;
      byte_cnt_q <= '0;
      run_stb_o  <= 1'b0;
      cmd_stb_o  <= 1'b0;
    end else begin
      run_stb_o <= 1'b0;
      cmd_stb_o <= 1'b0;
      // end of frame, back to idle
      if (!udp_rx_i.active) begin
        state_q    <= ST_HDR;
        byte_cnt_q <= '0;
      end else if (byte_stb) begin
        byte_cnt_q <= byte_cnt_q + 3'd1;
        case (state_q)
          ST_HDR: begin
            if (!port_ok) begin
              state_q <= ST_DISCARD;
            end else if (byte_cnt_q == 3'd0) begin
              if (rx_byte != HL_SYNC0) state_q <= ST_DISCARD;
            end else begin
              state_q <= (rx_byte == HL_SYNC1) ? ST_TYPE : ST_DISCARD;
            end
          end
          ST_TYPE: begin
            if (rx_byte == HL_TYPE_RUN) begin
              state_q <= ST_RUN;
            end else if (rx_byte == HL_TYPE_CMD) begin
              state_q <= ST_CMD;
            end else begin
              state_q <= ST_DISCARD;
            end
          end
          ST_RUN: begin
            run_stb_o <= 1'b1;
            state_q   <= ST_DISCARD;
          end
          ST_CMD: begin
            // byte 7 completes the data word
            if (byte_cnt_q == 3'd7) begin
              cmd_stb_o <= 1'b1;
              state_q   <= ST_DISCARD;
            end
          end
          default: state_q <= ST_DISCARD;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // field assembly
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (byte_stb && state_q == ST_RUN) begin
      run_o <= rx_byte[0];
    end
    if (byte_stb && state_q == ST_CMD) begin
      if (byte_cnt_q == 3'd3) begin
        cmd_q.resp_rqst <= rx_byte[7];
        cmd_q.addr      <= rx_byte[6:1];
        cmd_q.ptt       <= rx_byte[0];
      end else begin
        // msb first
        cmd_q.data <= {cmd_q.data[23:0], rx_byte};
      end
      if (byte_cnt_q == 3'd7) begin
        cmd_o.addr      <= cmd_q.addr;
        cmd_o.data      <= {cmd_q.data[23:0], rx_byte};
        cmd_o.ptt       <= cmd_q.ptt;
        cmd_o.resp_rqst <= cmd_q.resp_rqst;
      end
    end
  end

endmodule

/* source/hl_proto_pkg.sv */
// HL protocol package
// byte, port and header constants of the UDP frames, and the
// byte-stream structs used on the network side of the core

package hl_proto_pkg;

  ////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////

  // one frame byte
  typedef logic [7:0] hl_byte_t;

  // udp port number
  typedef logic [15:0] hl_port_t;

  ////////////////////////////////////////////////////////////
  // frame constants
  ////////////////////////////////////////////////////////////

  // only destination port we listen on
  localparam hl_port_t HL_DS_PORT = 16'd1024;

  // sync header, bytes 0 and 1
  localparam hl_byte_t HL_SYNC0 = 8'hEF;
  localparam hl_byte_t HL_SYNC1 = 8'hFE;

  // frame type, byte 2
  localparam hl_byte_t HL_TYPE_CMD  = 8'h01;
  localparam hl_byte_t HL_TYPE_RESP = 8'h02;
  localparam hl_byte_t HL_TYPE_RUN  = 8'h04;

  ////////////////////////////////////////////////////////////
  // byte streams
  ////////////////////////////////////////////////////////////

  // downstream, one byte per valid while active is high
  typedef struct packed {
    logic     active;
    logic     valid;
    hl_port_t port;
    hl_byte_t data;
  } hl_udp_rx_t;

  // upstream, last flags the final byte of a frame
  typedef struct packed {
    logic     valid;
    logic     last;
    hl_byte_t data;
  } hl_udp_tx_t;

endpackage

/* source/hl_radio_pkg.sv */
// HL radio package
// command and response payload types and the register map of the
// control block

package hl_radio_pkg;

  ////////////////////////////////////////////////////////////
  // command fields
  ////////////////////////////////////////////////////////////

  // register address carried in byte 3
  typedef logic [5:0] hl_cmd_addr_t;

  // register data, bytes 4 to 7
  typedef logic [31:0] hl_cmd_data_t;

  // one decoded command frame
  typedef struct packed {
    hl_cmd_addr_t addr;
    hl_cmd_data_t data;
    logic         ptt;
    logic         resp_rqst;
  } hl_cmd_t;

  // payload of an upstream response, byte 3 is {run, addr, tx_on}
  typedef struct packed {
    logic         run;
    hl_cmd_addr_t addr;
    logic         tx_on;
    hl_cmd_data_t data;
  } hl_resp_t;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  // bit 0 selects the rf switch
  localparam hl_cmd_addr_t HL_ADDR_RFFE = 6'h00;
  // bit 0 enables the pa
  localparam hl_cmd_addr_t HL_ADDR_PA   = 6'h09;

endpackage

/* source/hl_us_response.sv */
// HL upstream response sender
// serializes a captured response payload into one 8-byte frame,
// one byte per cycle

`timescale 1ns/100ps

module hl_us_response
  import hl_proto_pkg::*, hl_radio_pkg::*;
(
  input  logic       clk_ctrl,
  input  logic       rst_n_i,
  input  logic       resp_stb_i,
  input  hl_resp_t   resp_i,
  output hl_udp_tx_t udp_tx_o
);

  localparam logic [2:0] LAST_BYTE = 3'd7;

  hl_resp_t   resp_q;
  logic       busy_q;
  logic [2:0] byte_cnt_q;
  hl_byte_t   tx_byte;

  // payload, held for the whole frame
  always_ff @(posedge clk_ctrl) begin
    if (resp_stb_i) begin
      resp_q <= resp_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // byte counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      byte_cnt_q <= '0;
    end else if (resp_stb_i) begin
      busy_q     <= 1'b1;
      byte_cnt_q <= '0;
    end else if (busy_q) begin
      byte_cnt_q <= byte_cnt_q + 3'd1;
      if (byte_cnt_q == LAST_BYTE) busy_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame bytes
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (byte_cnt_q)
      3'd0:    tx_byte = HL_SYNC0;
      3'd1:    tx_byte = HL_SYNC1;
      3'd2:    tx_byte = HL_TYPE_RESP;
      3'd3:    tx_byte = {resp_q.run, resp_q.addr, resp_q.tx_on};
      3'd4:    tx_byte = resp_q.data[31:24];
      3'd5:    tx_byte = resp_q.data[23:16];
      3'd6:    tx_byte = resp_q.data[15:8];
      default: tx_byte = resp_q.data[7:0];
    endcase
  end

  assign udp_tx_o.valid = busy_q;
  assign udp_tx_o.last  = busy_q & (byte_cnt_q == LAST_BYTE);
  assign udp_tx_o.data  = tx_byte;

endmodule
